// File: mips_pkg.sv
// Word-only MIPS subset; no HI/LO, no byte or halfword access, undefined opcodes run as NOP
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;     // Data word or byte address
    typedef logic [4:0]  reg_addr_t; // GPR number
    typedef logic [15:0] imm_t;      // I-type immediate
    typedef logic [4:0]  shamt_t;    // Constant shift amount

    localparam word_t     RESET_VECTOR = 32'hBFC0_0000; // First fetch after reset
    localparam reg_addr_t V0_REG       = 5'd2;          // Result register tapped to the port
    localparam logic [3:0] BYTE_EN_ALL = 4'hF;          // Word transfers only

    // Kept primary opcodes
    typedef enum logic [5:0] {
        OP_RTYPE = 6'd0,
        OP_J     = 6'd2,
        OP_BEQ   = 6'd4,
        OP_BNE   = 6'd5,
        OP_ADDIU = 6'd9,
        OP_SLTI  = 6'd10,
        OP_SLTIU = 6'd11,
        OP_ANDI  = 6'd12,
        OP_ORI   = 6'd13,
        OP_XORI  = 6'd14,
        OP_LUI   = 6'd15,
        OP_LW    = 6'd35,
        OP_SW    = 6'd43
    } opcode_t;

    // R-type function codes
    typedef enum logic [5:0] {
        FN_SLL  = 6'd0,
        FN_SRL  = 6'd2,
        FN_SRA  = 6'd3,
        FN_JR   = 6'd8,
        FN_ADDU = 6'd33,
        FN_SUBU = 6'd35,
        FN_AND  = 6'd36,
        FN_OR   = 6'd37,
        FN_XOR  = 6'd38,
        FN_SLT  = 6'd42,
        FN_SLTU = 6'd43
    } funct_t;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM,
        HALT
    } cpu_state_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        PC_SEQ, PC_BEQ, PC_BNE, PC_JUMP, PC_JREG
    } pc_cmd_t;

    // Low half of the instruction word, read as R-type fields or as immediate
    typedef struct packed {
        reg_addr_t rd;
        shamt_t    shamt;
        funct_t    funct;
    } r_fields_t;

    typedef union packed {
        r_fields_t r;
        imm_t      imm;
    } instr_low_t;

    typedef struct packed {
        opcode_t    opcode; // [31:26]
        reg_addr_t  rs;     // [25:21]
        reg_addr_t  rt;     // [20:16]
        instr_low_t low;    // [15:0]
    } instr_fields_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      use_imm;  // Immediate replaces rt as operand b
        logic      zero_ext; // ANDI/ORI/XORI
        logic      reg_we;
        reg_addr_t dest;     // rd for R-type, rt for I-type
        logic      from_mem; // LW write-back
    } ctrl_t;

endpackage

`default_nettype wire

// File: mips_control.sv
// One instruction in flight, no delay slot; halts when a fetch would start at address zero
`timescale 1ns/1ps
`default_nettype none

module mips_control (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    waitrequest,
    input  wire mips_pkg::word_t         readdata,
    input  wire mips_pkg::word_t         pc,
    input  wire mips_pkg::word_t         alu_result,
    output mips_pkg::instr_fields_t      fields,
    output mips_pkg::ctrl_t              ctrl,
    output mips_pkg::pc_cmd_t            pc_cmd,
    output logic                         pc_advance,
    output logic                         reg_commit,
    output logic                         read,
    output logic                         write,
    output mips_pkg::word_t              address,
    output logic [3:0]                   byteenable,
    output logic                         active
);

    mips_pkg::cpu_state_t state, state_next;
    logic is_lw, is_sw;
    logic halt_fetch; // Fetch from address zero ends the run

    // Instruction register, loaded when the fetch completes
    always_ff @(posedge clk) begin
        if (state == mips_pkg::FETCH && !halt_fetch && !waitrequest) begin
            fields <= mips_pkg::instr_fields_t'(readdata);
        end
    end

    assign is_lw = (fields.opcode == mips_pkg::OP_LW);
    assign is_sw = (fields.opcode == mips_pkg::OP_SW);

    // Decode
    always_comb begin
        ctrl.alu_op   = mips_pkg::ALU_ADD;
        ctrl.use_imm  = 1'b1;
        ctrl.zero_ext = 1'b0;
        ctrl.reg_we   = 1'b1;
        ctrl.dest     = fields.rt; // I-type default
        ctrl.from_mem = 1'b0;
        pc_cmd        = mips_pkg::PC_SEQ;
        case (fields.opcode)
            mips_pkg::OP_RTYPE: begin
                ctrl.use_imm = 1'b0;
                ctrl.dest    = fields.low.r.rd;
                case (fields.low.r.funct)
                    mips_pkg::FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_XOR:  ctrl.alu_op = mips_pkg::ALU_XOR;
                    mips_pkg::FN_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_SLTU: ctrl.alu_op = mips_pkg::ALU_SLTU;
                    mips_pkg::FN_SLL:  ctrl.alu_op = mips_pkg::ALU_SLL;
                    mips_pkg::FN_SRL:  ctrl.alu_op = mips_pkg::ALU_SRL;
                    mips_pkg::FN_SRA:  ctrl.alu_op = mips_pkg::ALU_SRA;
                    mips_pkg::FN_JR: begin
                        ctrl.reg_we = 1'b0;
                        pc_cmd      = mips_pkg::PC_JREG;
                    end
                    default: ctrl.reg_we = 1'b0; // Unknown funct is a NOP
                endcase
            end
            mips_pkg::OP_J: begin
                ctrl.reg_we = 1'b0;
                pc_cmd      = mips_pkg::PC_JUMP;
            end
            mips_pkg::OP_BEQ: begin
                ctrl.reg_we = 1'b0;
                pc_cmd      = mips_pkg::PC_BEQ;
            end
            mips_pkg::OP_BNE: begin
                ctrl.reg_we = 1'b0;
                pc_cmd      = mips_pkg::PC_BNE;
            end
            mips_pkg::OP_ADDIU: ctrl.alu_op = mips_pkg::ALU_ADD;
            mips_pkg::OP_SLTI:  ctrl.alu_op = mips_pkg::ALU_SLT;
            mips_pkg::OP_SLTIU: ctrl.alu_op = mips_pkg::ALU_SLTU; // Sign-extended, unsigned compare
            mips_pkg::OP_ANDI: begin
                ctrl.alu_op   = mips_pkg::ALU_AND;
                ctrl.zero_ext = 1'b1;
            end
            mips_pkg::OP_ORI: begin
                ctrl.alu_op   = mips_pkg::ALU_OR;
                ctrl.zero_ext = 1'b1;
            end
            mips_pkg::OP_XORI: begin
                ctrl.alu_op   = mips_pkg::ALU_XOR;
                ctrl.zero_ext = 1'b1;
            end
            mips_pkg::OP_LUI:   ctrl.alu_op = mips_pkg::ALU_LUI;
            mips_pkg::OP_LW:    ctrl.from_mem = 1'b1; // Address = rs + imm
            mips_pkg::OP_SW:    ctrl.reg_we = 1'b0;
            default:            ctrl.reg_we = 1'b0; // Undefined opcode, NOP
        endcase
    end

    assign halt_fetch = (state == mips_pkg::FETCH) && (pc == '0);

    always_comb begin
        state_next = state;
        case (state)
            mips_pkg::FETCH: begin
                if (halt_fetch) begin
                    state_next = mips_pkg::HALT;
                end else if (!waitrequest) begin
                    state_next = mips_pkg::EXEC;
                end
            end
            mips_pkg::EXEC: state_next = (is_lw || is_sw) ? mips_pkg::MEM : mips_pkg::FETCH;
            mips_pkg::MEM:  state_next = waitrequest ? mips_pkg::MEM : mips_pkg::FETCH;
            default:        state_next = mips_pkg::HALT; // Left only by reset
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= mips_pkg::FETCH;
        end else begin
            state <= state_next;
        end
    end

    // LW holds its PC and register update until the data returns
    assign pc_advance = (state == mips_pkg::EXEC && !is_lw)
                     || (state == mips_pkg::MEM && is_lw && !waitrequest);
    assign reg_commit = (state == mips_pkg::EXEC && ctrl.reg_we && !ctrl.from_mem)
                     || (state == mips_pkg::MEM && ctrl.from_mem && !waitrequest);

    // Avalon master side
    assign read       = (state == mips_pkg::FETCH && !halt_fetch) || (state == mips_pkg::MEM && is_lw);
    assign write      = (state == mips_pkg::MEM) && is_sw;
    assign address    = (state == mips_pkg::MEM) ? alu_result : pc; // Data or fetch address
    assign byteenable = mips_pkg::BYTE_EN_ALL;
    assign active     = (state != mips_pkg::HALT) && !halt_fetch;

endmodule

`default_nettype wire

// File: mips_pc.sv
// PC only moves on pc_advance; branch offsets are relative to PC+4, no delay slot
`timescale 1ns/1ps
`default_nettype none

module mips_pc (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire mips_pkg::instr_fields_t fields,
    input  wire mips_pkg::pc_cmd_t       pc_cmd,
    input  wire logic                    pc_advance,
    input  wire mips_pkg::word_t         rs_data,
    input  wire mips_pkg::word_t         rt_data,
    output mips_pkg::word_t              pc
);

    mips_pkg::word_t pc_seq;    // PC + 4
    mips_pkg::word_t pc_branch; // Taken branch target
    mips_pkg::word_t pc_jump;
    mips_pkg::word_t pc_next;

    assign pc_seq    = pc + 32'd4;
    assign pc_branch = pc_seq + {{14{fields.low.imm[15]}}, fields.low.imm, 2'b00};
    // 26-bit target spans rs, rt and the immediate
    assign pc_jump   = {pc_seq[31:28], fields.rs, fields.rt, fields.low.imm, 2'b00};

    always_comb begin
        case (pc_cmd)
            mips_pkg::PC_BEQ:  pc_next = (rs_data == rt_data) ? pc_branch : pc_seq;
            mips_pkg::PC_BNE:  pc_next = (rs_data != rt_data) ? pc_branch : pc_seq;
            mips_pkg::PC_JUMP: pc_next = pc_jump;
            mips_pkg::PC_JREG: pc_next = rs_data; // JR
            default:           pc_next = pc_seq;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= mips_pkg::RESET_VECTOR;
        end else if (pc_advance) begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// File: mips_regfile.sv
// 32 x 32 GPRs, cleared by reset; r0 reads zero and ignores writes
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire mips_pkg::instr_fields_t fields,
    input  wire mips_pkg::ctrl_t         ctrl,
    input  wire logic                    reg_commit,
    input  wire mips_pkg::word_t         alu_result,
    input  wire mips_pkg::word_t         readdata,
    output mips_pkg::word_t              rs_data,
    output mips_pkg::word_t              rt_data,
    output mips_pkg::word_t              register_v0
);

    mips_pkg::word_t regs [32];
    mips_pkg::word_t wb_data;

    assign wb_data = ctrl.from_mem ? readdata : alu_result; // LW takes bus data

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (reg_commit && ctrl.dest != '0) begin
            regs[ctrl.dest] <= wb_data;
        end
    end

    // Two asynchronous read ports
    assign rs_data     = regs[fields.rs];
    assign rt_data     = regs[fields.rt];
    assign register_v0 = regs[mips_pkg::V0_REG];

endmodule

`default_nettype wire

// File: mips_alu.sv
// Purely combinational; shifts use the shamt field only, no variable shifts
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
    input  wire mips_pkg::instr_fields_t fields,
    input  wire mips_pkg::ctrl_t         ctrl,
    input  wire mips_pkg::word_t         rs_data,
    input  wire mips_pkg::word_t         rt_data,
    output mips_pkg::word_t              alu_result
);

    mips_pkg::word_t imm_ext;
    mips_pkg::word_t op_a;
    mips_pkg::word_t op_b;
    mips_pkg::shamt_t shamt;

    // Logic immediates are zero-filled, the rest sign-filled
    assign imm_ext = ctrl.zero_ext ? {16'b0, fields.low.imm}
                                   : {{16{fields.low.imm[15]}}, fields.low.imm};

    assign op_a  = rs_data;
    assign op_b  = ctrl.use_imm ? imm_ext : rt_data;
    assign shamt = fields.low.r.shamt;

    always_comb begin
        case (ctrl.alu_op)
            mips_pkg::ALU_ADD:  alu_result = op_a + op_b; // Also LW/SW address
            mips_pkg::ALU_SUB:  alu_result = op_a - op_b;
            mips_pkg::ALU_AND:  alu_result = op_a & op_b;
            mips_pkg::ALU_OR:   alu_result = op_a | op_b;
            mips_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
            mips_pkg::ALU_SLT: begin
                alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            end
            mips_pkg::ALU_SLTU: begin
                alu_result = {31'b0, op_a < op_b};
            end
            // Shifts act on rt
            mips_pkg::ALU_SLL:  alu_result = rt_data << shamt;
            mips_pkg::ALU_SRL:  alu_result = rt_data >> shamt;
            mips_pkg::ALU_SRA:  alu_result = mips_pkg::word_t'($signed(rt_data) >>> shamt);
            mips_pkg::ALU_LUI:  alu_result = {fields.low.imm, 16'b0};
            default:            alu_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: mips_cpu_bus.sv
// Avalon-MM master, word transfers only; byteenable stays all ones and active falls on halt
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus (
    input  wire logic             clk,
    input  wire logic             reset,
    output logic                  active,
    output mips_pkg::word_t       register_v0,

    // Avalon-MM master
    output mips_pkg::word_t       address,
    output logic                  write,
    output logic                  read,
    input  wire logic             waitrequest,
    output mips_pkg::word_t       writedata,
    output logic [3:0]            byteenable,
    input  wire mips_pkg::word_t  readdata
);

    mips_pkg::instr_fields_t fields;
    mips_pkg::ctrl_t         ctrl;
    mips_pkg::pc_cmd_t       pc_cmd;
    logic                    pc_advance;
    logic                    reg_commit;
    mips_pkg::word_t         pc;
    mips_pkg::word_t         rs_data;
    mips_pkg::word_t         rt_data;
    mips_pkg::word_t         alu_result;

    assign writedata = rt_data; // SW data straight from the rt port

    mips_control mips_control_inst (
        .clk         (clk),
        .reset       (reset),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .pc          (pc),
        .alu_result  (alu_result),
        .fields      (fields),
        .ctrl        (ctrl),
        .pc_cmd      (pc_cmd),
        .pc_advance  (pc_advance),
        .reg_commit  (reg_commit),
        .read        (read),
        .write       (write),
        .address     (address),
        .byteenable  (byteenable),
        .active      (active)
    );

    mips_pc mips_pc_inst (
        .clk        (clk),
        .reset      (reset),
        .fields     (fields),
        .pc_cmd     (pc_cmd),
        .pc_advance (pc_advance),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .pc         (pc)
    );

    mips_regfile mips_regfile_inst (
        .clk         (clk),
        .reset       (reset),
        .fields      (fields),
        .ctrl        (ctrl),
        .reg_commit  (reg_commit),
        .alu_result  (alu_result),
        .readdata    (readdata),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .register_v0 (register_v0)
    );

    mips_alu mips_alu_inst (
        .fields     (fields),
        .ctrl       (ctrl),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .alu_result (alu_result)
    );

endmodule

`default_nettype wire

// File: mips_cpu_bus_assertions.sv
// Avalon master rules only; data values are left to the testbench model
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus_assertions (
    input wire logic            clk,
    input wire logic            reset,
    input wire logic            active,
    input wire logic            read,
    input wire logic            write,
    input wire logic            waitrequest,
    input wire mips_pkg::word_t address,
    input wire mips_pkg::word_t writedata,
    input wire logic [3:0]      byteenable
);

    one_strobe_a: assert property (@(posedge clk) disable iff (reset) !(read && write))
        else $error("read and write high in the same cycle");

    // Request frozen under back-pressure
    hold_request_a: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(read) && $stable(write))
        else $error("address or strobe changed while waitrequest was high");

    hold_data_a: assert property (@(posedge clk) disable iff (reset)
        write && waitrequest |=> $stable(writedata))
        else $error("writedata changed while waitrequest was high");

    idle_when_halted_a: assert property (@(posedge clk) disable iff (reset)
        !active |-> !read && !write)
        else $error("strobe high while the CPU is halted");

    full_word_a: assert property (@(posedge clk) disable iff (reset)
        write |-> byteenable == 4'hF)   // Word stores only
        else $error("partial byteenable on a write");

endmodule

bind mips_cpu_bus mips_cpu_bus_assertions mips_cpu_bus_assertions_inst (
    .clk         (clk),
    .reset       (reset),
    .active      (active),
    .read        (read),
    .write       (write),
    .waitrequest (waitrequest),
    .address     (address),
    .writedata   (writedata),
    .byteenable  (byteenable)
);

`default_nettype wire

// File: mips_cpu_bus_tb.sv
// Programs run from the reset vector and halt by jr $0; random wait states up to a per-run limit
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus_tb;

    typedef mips_pkg::word_t word_t;

    typedef struct packed {
        word_t addr;
        word_t data;
    } bus_xfer_t;

    logic       clk;
    logic       reset;
    logic       waitrequest;
    word_t      readdata;
    logic       active;
    word_t      register_v0;
    word_t      address;
    logic       write;
    logic       read;
    word_t      writedata;
    logic [3:0] byteenable;

    word_t     image [word_t];  // Program and data keyed by aligned address
    word_t     mem [word_t];    // Live copy served to the DUT
    word_t     load_ptr;
    word_t     exp_reads [$];   // Fetch and load addresses in order
    word_t     seen_reads [$];
    bus_xfer_t exp_writes [$];
    bus_xfer_t seen_writes [$];
    int        ref_count;       // Instructions run by the model
    int        wait_max;
    int        wait_left;
    logic      pending;         // Transfer seen but not yet completed
    int        error_count = 0;
    integer    seed = 32'h8da0_16c0;

    mips_cpu_bus mips_cpu_bus_inst (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic word_t aligned(input word_t a);
        return {a[31:2], 2'b00};
    endfunction

    // Unwritten words read back as a pattern of their own address
    function automatic word_t fill_word(input word_t a);
        return aligned(a) ^ 32'h5A5A_C3C3;
    endfunction

    function automatic word_t encode_r(input int rs, input int rt, input int rd,
                                       input int sh, input int fn);
        return {6'd0, 5'(rs), 5'(rt), 5'(rd), 5'(sh), 6'(fn)};
    endfunction

    function automatic word_t encode_i(input int op, input int rs, input int rt, input int imm);
        return {6'(op), 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic word_t encode_j(input word_t target);
        return {6'd2, target[27:2]};
    endfunction

    // Instruction-set model; fills the expected bus traffic and returns the final v0
    function automatic word_t run_reference();
        word_t rmem [word_t];
        word_t regs [32];
        word_t pc, ir, a, b, simm, zimm, val, next, ea;
        logic [4:0] dst;
        logic wr;
        rmem = image;
        foreach (regs[i]) regs[i] = '0;
        pc = mips_pkg::RESET_VECTOR;
        ref_count = 0;
        while (pc != '0 && ref_count < 10000) begin
            exp_reads.push_back(pc);
            ir   = rmem.exists(aligned(pc)) ? rmem[aligned(pc)] : fill_word(pc);
            a    = regs[ir[25:21]];
            b    = regs[ir[20:16]];
            simm = {{16{ir[15]}}, ir[15:0]};
            zimm = {16'h0, ir[15:0]};
            ea   = a + simm;
            next = pc + 32'd4;   // No delay slot
            wr   = 1'b1;
            dst  = ir[20:16];
            val  = '0;
            case (ir[31:26])
                6'd0: begin
                    dst = ir[15:11];
                    case (ir[5:0])
                        6'd0:  val = b << ir[10:6];
                        6'd2:  val = b >> ir[10:6];
                        6'd3:  val = $signed(b) >>> ir[10:6];
                        6'd8: begin
                            wr   = 1'b0;
                            next = a;          // JR
                        end
                        6'd33: val = a + b;
                        6'd35: val = a - b;
                        6'd36: val = a & b;
                        6'd37: val = a | b;
                        6'd38: val = a ^ b;
                        6'd42: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        6'd43: val = (a < b) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                6'd2: begin
                    wr   = 1'b0;
                    next = {next[31:28], ir[25:0], 2'b00};
                end
                6'd4: begin
                    wr = 1'b0;
                    if (a == b) next = next + (simm << 2);
                end
                6'd5: begin
                    wr = 1'b0;
                    if (a != b) next = next + (simm << 2);
                end
                6'd9:  val = ea;
                6'd10: val = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
                6'd11: val = (a < simm) ? 32'd1 : 32'd0;     // Sign-extended immediate compared unsigned
                6'd12: val = a & zimm;
                6'd13: val = a | zimm;
                6'd14: val = a ^ zimm;
                6'd15: val = {ir[15:0], 16'h0};
                6'd35: begin
                    exp_reads.push_back(ea);
                    val = rmem.exists(aligned(ea)) ? rmem[aligned(ea)] : fill_word(ea);
                end
                6'd43: begin
                    wr = 1'b0;
                    exp_writes.push_back(bus_xfer_t'({ea, b}));
                    rmem[aligned(ea)] = b;
                end
                default: wr = 1'b0;                        // Undefined opcode is a NOP
            endcase
            if (wr && dst != 5'd0) regs[dst] = val;
            pc = next;
            ref_count++;
        end
        return regs[2];
    endfunction

    task automatic stop_on_error(input string why);
        error_count++;
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            stop_on_error($sformatf("CHECK FAILED time %0t %s got %h expected %h",
                                    $time, name, got, expected));
        end
    endtask

    // Memory model called once per falling edge while the CPU runs
    task automatic serve_bus();
        word_t a;
        a = address;
        if (!read && !write) begin
            waitrequest = 1'b0;
            readdata    = '0;
        end else begin
            check("byteenable", byteenable, 4'hF);   // Word transfers only
            if (!pending) begin
                pending   = 1'b1;
                wait_left = (wait_max == 0) ? 0 : int'($unsigned($random(seed)) % (wait_max + 1));
            end
            if (wait_left > 0) begin
                waitrequest = 1'b1;   // Stall one more cycle
                readdata    = '0;
                wait_left--;
            end else begin
                waitrequest = 1'b0;   // Completes at the next rising edge
                pending     = 1'b0;
                if (read) begin
                    readdata = mem.exists(aligned(a)) ? mem[aligned(a)] : fill_word(a);
                    seen_reads.push_back(a);
                end else begin
                    mem[aligned(a)] = writedata;
                    seen_writes.push_back(bus_xfer_t'({a, writedata}));
                end
            end
        end
    endtask

    // Oldest completed transfers compared first
    always @(posedge clk) begin
        bus_xfer_t got_w;
        bus_xfer_t exp_w;
        while (seen_reads.size() > 0) begin
            if (exp_reads.size() == 0) stop_on_error("The DUT read more words than the model");
            check("read address", seen_reads.pop_front(), exp_reads.pop_front());
        end
        while (seen_writes.size() > 0) begin
            if (exp_writes.size() == 0) stop_on_error("The DUT wrote more words than the model");
            got_w = seen_writes.pop_front();
            exp_w = exp_writes.pop_front();
            check("write address", got_w.addr, exp_w.addr);
            check("writedata", got_w.data, exp_w.data);
        end
    end

    task automatic start_program();
        image.delete();
        load_ptr = mips_pkg::RESET_VECTOR;
        image[32'h0000_1020] = 32'h1357_9BDF;   // Data word for LW
    endtask

    task automatic emit(input word_t instr);
        image[load_ptr] = instr;
        load_ptr += 32'd4;
    endtask

    // Arithmetic, logic, shifts and compares folded into v0
    task automatic load_alu_program();
        start_program();
        emit(encode_i(9, 0, 8, -5));
        emit(encode_i(9, 0, 9, 7));
        emit(encode_r(8, 9, 10, 0, 33));        // addu
        emit(encode_r(8, 9, 11, 0, 35));        // subu gives a negative result
        emit(encode_r(8, 9, 12, 0, 42));        // slt true when signed
        emit(encode_r(8, 9, 13, 0, 43));        // sltu false when unsigned
        emit(encode_r(0, 11, 14, 2, 3));        // sra
        emit(encode_r(0, 11, 15, 4, 2));        // srl
        emit(encode_r(0, 9, 16, 3, 0));         // sll
        emit(encode_i(15, 0, 17, 16'h8001));    // lui
        emit(encode_i(13, 17, 17, 16'hF0F0));   // ori zero-extends
        emit(encode_i(12, 8, 18, 16'hFF00));    // andi
        emit(encode_i(14, 8, 19, 16'h8000));    // xori
        emit(encode_i(10, 9, 20, -1));          // slti 7 < -1 is false
        emit(encode_i(11, 9, 21, -1));          // sltiu against all ones
        emit(encode_r(8, 17, 22, 0, 36));
        emit(encode_r(8, 17, 23, 0, 37));
        emit(encode_r(8, 17, 24, 0, 38));
        emit(encode_i(10, 8, 25, -3));          // slti -5 < -3
        for (int r = 10; r <= 25; r++) begin
            emit(encode_r(0, 2, 2, 1, 0));      // v0 <<= 1
            emit(encode_r(2, r, 2, 0, 33));     // v0 += r
        end
        emit(encode_r(0, 0, 0, 0, 8));          // jr $0 halts
    endtask

    task automatic load_mem_program();
        start_program();
        emit(encode_i(9, 0, 8, 16'h1000));      // Base address
        emit(encode_i(15, 0, 9, 16'hCAFE));
        emit(encode_i(13, 9, 9, 16'hBABE));
        emit(encode_i(43, 8, 9, 0));            // sw
        emit(encode_i(9, 9, 10, 1));
        emit(encode_i(43, 8, 10, -4));          // sw with negative offset
        emit(encode_i(35, 8, 11, 16'h20));      // lw preloaded word
        emit(encode_i(35, 8, 12, 0));           // lw stored word
        emit(encode_r(11, 12, 2, 0, 33));
        emit(encode_i(43, 8, 2, 4));
        emit(encode_r(0, 0, 0, 0, 8));
    endtask

    // Word index in the comments
    task automatic load_branch_program();
        start_program();
        emit(encode_i(9, 0, 8, 3));             // 0
        emit(encode_i(9, 0, 9, 3));             // 1
        emit(encode_i(4, 8, 9, 1));             // 2 beq taken
        emit(encode_i(9, 0, 2, 16'h111));       // 3 skipped
        emit(encode_i(5, 8, 9, 1));             // 4 bne not taken
        emit(encode_i(9, 2, 2, 16'h20));        // 5
        emit(encode_i(9, 9, 9, 1));             // 6
        emit(encode_i(5, 8, 9, 1));             // 7 bne taken
        emit(encode_i(9, 2, 2, 16'h400));       // 8 skipped
        emit(encode_i(4, 8, 9, 1));             // 9 beq not taken
        emit(encode_i(9, 2, 2, 3));             // 10
        emit(encode_i(9, 0, 11, 4));            // 11 loop count
        emit(encode_i(9, 2, 2, 16'h100));       // 12 loop body
        emit(encode_i(9, 11, 11, -1));          // 13
        emit(encode_i(5, 11, 0, -3));           // 14 back to 12
        emit(encode_j(mips_pkg::RESET_VECTOR + 32'd72));  // 15 j to 18
        emit(encode_i(9, 2, 2, 16'h5000));      // 16 skipped
        emit(encode_i(9, 2, 2, 16'h6000));      // 17 skipped
        emit(encode_i(15, 0, 10, 16'hBFC0));    // 18
        emit(encode_i(13, 10, 10, 16'h0058));   // 19 address of 22
        emit(encode_r(10, 0, 0, 0, 8));         // 20 jr
        emit(encode_i(9, 2, 2, 16'h7000));      // 21 skipped
        emit(encode_i(9, 2, 2, 8));             // 22
        emit(encode_r(0, 0, 0, 0, 8));          // 23
    endtask

    task automatic load_zero_program();
        start_program();
        emit(encode_i(9, 0, 2, -1));            // v0 nonzero first
        emit(encode_i(9, 0, 0, 16'h55));
        emit(encode_i(15, 0, 0, 16'h1234));
        emit(encode_r(2, 2, 0, 0, 33));
        emit(encode_i(9, 0, 8, 16'h1000));
        emit(encode_i(35, 8, 0, 16'h20));       // lw into r0
        emit(encode_r(0, 0, 2, 0, 33));         // v0 = r0
        emit(encode_r(0, 0, 0, 0, 8));
    endtask

    task automatic run_program(input int max_wait, output word_t v0_out);
        word_t v0_exp;
        int    limit;
        int    cycles;
        exp_reads.delete();
        exp_writes.delete();
        seen_reads.delete();
        seen_writes.delete();
        v0_exp      = run_reference();
        limit       = 4 * ref_count * (max_wait + 1) + 50;
        mem         = image;
        wait_max    = max_wait;
        pending     = 1'b0;
        reset       = 1'b1;
        waitrequest = 1'b0;
        readdata    = '0;
        repeat (3) @(negedge clk);
        reset  = 1'b0;
        cycles = 0;
        while (active) begin
            serve_bus();
            @(negedge clk);
            cycles++;
            if (cycles > limit) begin
                stop_on_error($sformatf("Timeout, the CPU was still active after %0d cycles",
                                        limit));
            end
        end
        waitrequest = 1'b0;
        readdata    = '0;
        // Bus stays idle once halted at address zero
        repeat (10) begin
            check("active", active, 0);
            check("read", read, 0);
            check("write", write, 0);
            @(negedge clk);
        end
        check("model reads not seen", exp_reads.size(), 0);
        check("model writes not seen", exp_writes.size(), 0);
        check("register_v0", register_v0, v0_exp);
        v0_out = register_v0;
    endtask

    initial begin
        word_t v0_plain;
        word_t v0_waits;
        word_t v0_other;
        reset       = 1'b1;
        waitrequest = 1'b0;
        readdata    = '0;
        load_alu_program();
        run_program(0, v0_plain);
        load_mem_program();
        run_program(0, v0_other);
        load_branch_program();
        run_program(0, v0_other);
        load_zero_program();
        run_program(0, v0_other);
        check("register_v0 copied from r0", v0_other, 32'h0);
        load_alu_program();
        run_program(3, v0_waits);               // Same program under back-pressure
        check("register_v0 with wait states", v0_waits, v0_plain);
        load_mem_program();
        run_program(2, v0_other);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
mips_pkg.sv
mips_control.sv
mips_pc.sv
mips_regfile.sv
mips_alu.sv
mips_cpu_bus.sv
mips_cpu_bus_assertions.sv
mips_cpu_bus_tb.sv

// File: Bender.yml
package:
  name: mips_cpu_bus

sources:
  - files:
      - mips_pkg.sv
      - mips_control.sv
      - mips_pc.sv
      - mips_regfile.sv
      - mips_alu.sv
      - mips_cpu_bus.sv
  - target: test
    files:
      - mips_cpu_bus_assertions.sv
      - mips_cpu_bus_tb.sv
